/* source/div_pkg.sv */
// shared widths, encodings and state type for the iterative divider
// imported by the divider RTL and by the testbench

`default_nettype none

package div_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // operand width, both dividend and divisor
  localparam int DATA_W = 32;

  // response packs remainder above quotient
  localparam int RESULT_W = 2 * DATA_W;

  // one restoring step per operand bit
  localparam int NUM_STEPS = DATA_W;

  // enough bits to hold NUM_STEPS - 1
  localparam int STEP_CNT_W = 5;

  // --------------------------------------------------------------------------
  // encodings
  // --------------------------------------------------------------------------

  // request function bit
  typedef enum logic {
    FN_UNSIGNED = 1'b0,
    FN_SIGNED   = 1'b1
  } div_fn_e;

  // controller states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

/* source/div_step_if.sv */
// control/status bundle between the divider FSM and the shift-subtract datapath
// ctrl side steers the datapath, dpath side reports the trial sign

`timescale 1ns/1ps
`default_nettype none

interface div_step_if;

  // capture operand magnitudes into the datapath
  logic load;

  // perform one shift-subtract iteration
  logic step;

  // keep the shifted remainder, quotient bit zero
  logic restore;

  // sign of the trial difference, high when divisor does not fit
  logic sub_neg;

  // controller view
  modport ctrl (
    output load,
    output step,
    output restore,
    input  sub_neg
  );

  // datapath view
  modport dpath (
    input  load,
    input  step,
    input  restore,
    output sub_neg
  );

endinterface

`default_nettype wire

/* source/div_ctrl.sv */
// divider control FSM: accepts a request, runs the 32 steps, holds the response
// only the state is registered; all outputs decode from state and inputs

`timescale 1ns/1ps
`default_nettype none

module div_ctrl import div_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       req_val,
  output logic       req_rdy,
  output logic       resp_val,
  input  logic       resp_rdy,
  input  logic       last,
  output logic       cnt_load,
  output logic       cnt_step,
  div_step_if.ctrl   step_bus
);

  div_state_e state;
  div_state_e state_next;

  logic accept;
  logic respond;
  logic in_calc;

  // --------------------------------------------------------------------------
  // handshakes
  // --------------------------------------------------------------------------

  // ready only while idle, independent of req_val
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  assign accept  = req_val && req_rdy;
  assign respond = resp_val && resp_rdy;
  assign in_calc = (state == CALC);

  // --------------------------------------------------------------------------
  // datapath and counter steering
  // --------------------------------------------------------------------------

  // operands and counter load on the accept edge
  assign step_bus.load = accept;
  assign cnt_load      = accept;

  // one step per cycle for the whole of CALC
  assign step_bus.step = in_calc;
  assign cnt_step      = in_calc;

  // negative trial difference means the divisor did not fit
  assign step_bus.restore = in_calc && step_bus.sub_neg;

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (accept) state_next = CALC;
      // counter reports the final step
      CALC: if (last) state_next = DONE;
      // hold under back-pressure
      DONE: if (respond) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // request and response sides never open at once
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // datapath only steps right after an accept or after a step that was not the last
  a_step_in_calc: assert property (@(posedge clk) disable iff (reset)
    step_bus.step |-> ($past(accept) || ($past(step_bus.step) && !$past(last))))
    else $error("step outside CALC");

endmodule

`default_nettype wire

/* source/div_step_counter.sv */
// counts the division steps still to run and flags the final one
// loaded on accept, decremented once per step

`timescale 1ns/1ps
`default_nettype none

module div_step_counter import div_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last
);

  // steps remaining after the current one
  logic [STEP_CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      // first step runs with count at NUM_STEPS - 1
      count <= STEP_CNT_W'(NUM_STEPS - 1);
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

  // zero count marks the step that finishes the division
  assign last = (count == '0);

  // a step at zero count is the final one, no further step may follow
  // without a reload, otherwise the count would wrap
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    (step && !load && count == '0) |=> !step || load)
    else $error("step counter underflow");

endmodule

`default_nettype wire

/* source/div_shift_sub.sv */
// restoring shift-subtract datapath for unsigned magnitudes
// after 32 steps the remainder sits in bits 63:32, the quotient in bits 31:0

`timescale 1ns/1ps
`default_nettype none

module div_shift_sub import div_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  div_step_if.dpath         step_bus,
  input  logic [DATA_W-1:0] mag_a,
  input  logic [DATA_W-1:0] mag_b,
  output logic [DATA_W-1:0] quot_raw,
  output logic [DATA_W-1:0] rem_raw
);

  // partial remainder above, dividend bits shifting out and quotient bits in
  logic [2*DATA_W:0] rq_reg;

  // divisor aligned to the remainder half
  logic [2*DATA_W:0] div_reg;

  logic [2*DATA_W:0] shifted;
  logic [2*DATA_W:0] diff;

  // --------------------------------------------------------------------------
  // one restoring step
  // --------------------------------------------------------------------------

  assign shifted = rq_reg << 1;
  assign diff    = shifted - div_reg;

  // borrow out of the top bit, remainder smaller than divisor
  assign step_bus.sub_neg = diff[2*DATA_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_reg  <= '0;
      div_reg <= '0;
    end else if (step_bus.load) begin
      rq_reg  <= {{(DATA_W+1){1'b0}}, mag_a};
      div_reg <= {1'b0, mag_b, {DATA_W{1'b0}}};
    end else if (step_bus.step) begin
      if (step_bus.restore) begin
        // divisor did not fit
        rq_reg <= {shifted[2*DATA_W:1], 1'b0};
      end else begin
        rq_reg <= {diff[2*DATA_W:1], 1'b1};
      end
    end
  end

  // raw unsigned results
  assign quot_raw = rq_reg[DATA_W-1:0];
  assign rem_raw  = rq_reg[2*DATA_W-1:DATA_W];

  // a load mid-division would corrupt the running remainder
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(step_bus.load && step_bus.step))
    else $error("load and step high together");

endmodule

`default_nettype wire

/* source/div_sign_unit.sv */
// sign handling around the unsigned engine: magnitudes in, signed result out
// result signs are captured on load and held for the whole division

`timescale 1ns/1ps
`default_nettype none

module div_sign_unit import div_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,
  input  div_fn_e             req_fn,
  input  logic [DATA_W-1:0]   req_a,
  input  logic [DATA_W-1:0]   req_b,
  output logic [DATA_W-1:0]   mag_a,
  output logic [DATA_W-1:0]   mag_b,
  input  logic [DATA_W-1:0]   quot_raw,
  input  logic [DATA_W-1:0]   rem_raw,
  output logic [RESULT_W-1:0] result
);

  logic is_signed;
  logic a_neg;
  logic b_neg;

  logic quot_neg;
  logic rem_neg;

  logic [DATA_W-1:0] quot_out;
  logic [DATA_W-1:0] rem_out;

  // --------------------------------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------------------------------

  // sign bits only count for the signed function
  assign is_signed = (req_fn == FN_SIGNED);
  assign a_neg     = is_signed && req_a[DATA_W-1];
  assign b_neg     = is_signed && req_b[DATA_W-1];

  // most negative value maps onto itself, still correct as unsigned
  assign mag_a = a_neg ? (~req_a + DATA_W'(1)) : req_a;
  assign mag_b = b_neg ? (~req_b + DATA_W'(1)) : req_b;

  // quotient negative when signs differ, remainder follows the dividend
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (load) begin
      quot_neg <= a_neg ^ b_neg;
      rem_neg  <= a_neg;
    end
  end

  // --------------------------------------------------------------------------
  // signed result
  // --------------------------------------------------------------------------

  assign quot_out = quot_neg ? (~quot_raw + DATA_W'(1)) : quot_raw;
  assign rem_out  = rem_neg ? (~rem_raw + DATA_W'(1)) : rem_raw;

  // remainder in the upper half
  assign result = {rem_out, quot_out};

endmodule

`default_nettype wire

/* source/int_div_iterative.sv */
// top level of the iterative 32-bit divider, one request in flight
// request and response use valid/ready handshakes, result is {remainder, quotient}

`timescale 1ns/1ps
`default_nettype none

module int_div_iterative import div_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  div_fn_e             req_fn,
  input  logic [DATA_W-1:0]   req_a,
  input  logic [DATA_W-1:0]   req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [RESULT_W-1:0] resp_result
);

  // counter handshake
  logic cnt_load;
  logic cnt_step;
  logic last;

  // magnitudes into the engine and raw results back out
  logic [DATA_W-1:0] mag_a;
  logic [DATA_W-1:0] mag_b;
  logic [DATA_W-1:0] quot_raw;
  logic [DATA_W-1:0] rem_raw;

  // controller to datapath bundle
  div_step_if u_step_if ();

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  div_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .last     (last),
    .cnt_load (cnt_load),
    .cnt_step (cnt_step),
    .step_bus (u_step_if.ctrl)
  );

  div_step_counter u_div_step_counter (
    .clk   (clk),
    .reset (reset),
    .load  (cnt_load),
    .step  (cnt_step),
    .last  (last)
  );

  // --------------------------------------------------------------------------
  // data
  // --------------------------------------------------------------------------

  div_shift_sub u_div_shift_sub (
    .clk      (clk),
    .reset    (reset),
    .step_bus (u_step_if.dpath),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .quot_raw (quot_raw),
    .rem_raw  (rem_raw)
  );

  // signs latch on the same edge as the operands
  div_sign_unit u_div_sign_unit (
    .clk      (clk),
    .reset    (reset),
    .load     (u_step_if.load),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .quot_raw (quot_raw),
    .rem_raw  (rem_raw),
    .result   (resp_result)
  );

endmodule

`default_nettype wire

/* tests/div_ref.svh */
// reference model for the divider response, built from the division rules
// included inside the testbench module after the package import

`ifndef DIV_REF_SVH
`define DIV_REF_SVH

  // negative operand only counts for the signed function
  function automatic logic operand_is_neg(div_fn_e fn, logic [DATA_W-1:0] v);
    return (fn == FN_SIGNED) && v[DATA_W-1];
  endfunction

  // two's complement magnitude, most negative value stays as is
  function automatic logic [DATA_W-1:0] magnitude_of(logic [DATA_W-1:0] v, logic neg);
    logic [DATA_W-1:0] m;
    m = neg ? -v : v;
    return m;
  endfunction

  // expected {remainder, quotient} for one request
  function automatic logic [RESULT_W-1:0] expected_result(div_fn_e fn,
                                                         logic [DATA_W-1:0] a,
                                                         logic [DATA_W-1:0] b);
    logic a_neg;
    logic b_neg;
    logic [DATA_W-1:0] ma;
    logic [DATA_W-1:0] mb;
    logic [DATA_W-1:0] q;
    logic [DATA_W-1:0] r;
    a_neg = operand_is_neg(fn, a);
    b_neg = operand_is_neg(fn, b);
    ma = magnitude_of(a, a_neg);
    mb = magnitude_of(b, b_neg);
    if (mb == '0) begin
      // divide by zero: all ones quotient, dividend as remainder
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    // quotient sign from the operand signs, remainder from the dividend
    if (a_neg ^ b_neg) q = -q;
    if (a_neg) r = -r;
    return {r, q};
  endfunction

`endif

/* tests/tb_int_div.sv */
// testbench for the iterative divider: random and corner requests with
// request stalls and response back-pressure, checked by concurrent assertions

`timescale 1ns/1ps
`default_nettype none

module tb_int_div import div_pkg::*; ();

  `include "div_ref.svh"

  localparam int CYCLE_LIMIT = 12000;
  localparam int LATENCY = 32;

  logic                clk;
  logic                reset;
  logic                req_val;
  logic                req_rdy;
  div_fn_e             req_fn;
  logic [DATA_W-1:0]   req_a;
  logic [DATA_W-1:0]   req_b;
  logic                resp_val;
  logic                resp_rdy;
  logic [RESULT_W-1:0] resp_result;

  // request list
  div_fn_e           fn_q[$];
  logic [DATA_W-1:0] a_q[$];
  logic [DATA_W-1:0] b_q[$];

  // dividends used against a zero divisor
  logic [DATA_W-1:0] ma_list[5] = '{32'd0, 32'd7, 32'h8000_0000, 32'hffff_fff9,
                                    32'h1234_5678};

  // scoreboard state, one request in flight
  logic [RESULT_W-1:0] exp_cur;
  logic busy;
  int   since_accept;
  int   n_resp;
  int   cycles;
  int   value_errs;
  int   proto_errs;

  int stall_left;
  logic stall_armed;

  int_div_iterative u_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // scoreboard and watchdog
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (reset) begin
      busy <= 1'b0;
      since_accept <= 0;
    end else if (req_val && req_rdy) begin
      // expected value taken on the accept edge
      exp_cur <= expected_result(req_fn, req_a, req_b);
      busy <= 1'b1;
      since_accept <= 0;
    end else begin
      since_accept <= since_accept + 1;
      if (resp_val && resp_rdy) begin
        busy <= 1'b0;
        n_resp <= n_resp + 1;
      end
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d responses seen",
               cycles, n_resp, fn_q.size());
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------

  a_result: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp_result == exp_cur))
    else begin
      value_errs++;
      $display("ERR %0t resp_result expected %h actual %h",
               $time, $sampled(exp_cur), $sampled(resp_result));
    end

  // first high sample of resp_val, 32 steps after the accept
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !$past(resp_val)) |-> (since_accept == LATENCY))
    else begin
      value_errs++;
      $display("ERR %0t resp_val latency expected %0d actual %0d",
               $time, LATENCY, $sampled(since_accept));
    end

  a_busy_rdy: assert property (@(posedge clk) disable iff (reset)
    busy |-> !req_rdy)
    else begin
      proto_errs++;
      $display("req_rdy went high before the response transfer at %0t", $time);
    end

  // back-pressure holds the response and blocks new requests
  a_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result) && !req_rdy))
    else begin
      proto_errs++;
      $display("response not held under back-pressure at %0t", $time);
    end

  a_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> (req_rdy && !resp_val))
    else begin
      proto_errs++;
      $display("wrong handshake outputs on the first cycle after reset");
    end

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------

  task automatic add_req(div_fn_e fn, logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    fn_q.push_back(fn);
    a_q.push_back(a);
    b_q.push_back(b);
  endtask

  task automatic build_requests();
    logic [DATA_W-1:0] ma;
    logic [DATA_W-1:0] mb;
    logic [DATA_W-1:0] r;
    for (int i = 0; i < 80; i++) begin
      add_req(FN_UNSIGNED, $urandom, $urandom >> $urandom_range(0, 31));
    end
    // all four sign combinations in turn
    for (int i = 0; i < 80; i++) begin
      ma = $urandom & 32'h7fff_ffff;
      mb = ($urandom & 32'h7fff_ffff) >> $urandom_range(0, 30);
      if (mb == '0) mb = 32'd1;
      add_req(FN_SIGNED, i[0] ? -ma : ma, i[1] ? -mb : mb);
    end
    // divide by zero
    foreach (ma_list[k]) begin
      add_req(FN_UNSIGNED, ma_list[k], '0);
      add_req(FN_SIGNED, ma_list[k], '0);
    end
    add_req(FN_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    add_req(FN_SIGNED, 32'h8000_0000, 32'd1);
    add_req(FN_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
    // dividend smaller than divisor
    add_req(FN_UNSIGNED, 32'd5, 32'd9);
    add_req(FN_SIGNED, 32'd5, 32'd9);
    add_req(FN_SIGNED, -32'd5, 32'd9);
    add_req(FN_SIGNED, 32'd5, -32'd9);
    add_req(FN_UNSIGNED, 32'd3, 32'hffff_ffff);
    // divisor one
    for (int i = 0; i < 6; i++) begin
      r = $urandom;
      add_req(FN_UNSIGNED, r, 32'd1);
      add_req(FN_SIGNED, r, 32'd1);
      add_req(FN_SIGNED, r, 32'hffff_ffff);
    end
  endtask

  // response sink, a fresh 0 to 5 cycle stall for each response
  initial begin
    stall_left = 0;
    stall_armed = 1'b0;
    forever begin
      @(negedge clk);
      if (!resp_val) begin
        stall_armed = 1'b0;
        resp_rdy = ($urandom_range(0, 1) == 1);
      end else begin
        if (!stall_armed) begin
          stall_armed = 1'b1;
          stall_left = $urandom_range(0, 5);
        end
        if (stall_left > 0) begin
          resp_rdy = 1'b0;
          stall_left--;
        end else begin
          resp_rdy = 1'b1;
        end
      end
    end
  end

  initial begin
    void'($urandom(60565));
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = FN_UNSIGNED;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b0;
    cycles = 0;
    n_resp = 0;
    value_errs = 0;
    proto_errs = 0;
    exp_cur = '0;
    build_requests();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < fn_q.size(); i++) begin
      repeat ($urandom_range(0, 3)) @(negedge clk);
      req_val = 1'b1;
      req_fn = fn_q[i];
      req_a = a_q[i];
      req_b = b_q[i];
      // req_rdy only moves on the rising edge, so it is stable here
      while (!req_rdy) @(negedge clk);
      @(negedge clk);
      req_val = 1'b0;
    end
    wait (n_resp == fn_q.size());
    repeat (4) @(negedge clk);
    $display("%0d requests, %0d responses, %0d value errors, %0d protocol errors",
             fn_q.size(), n_resp, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+tests
source/div_pkg.sv
source/div_step_if.sv
source/div_ctrl.sv
source/div_step_counter.sv
source/div_shift_sub.sv
source/div_sign_unit.sv
source/int_div_iterative.sv
tests/tb_int_div.sv

/* run.sh */
#!/bin/sh
# build the divider testbench with Verilator and run it
# exit status is zero only when the pass message shows up in the output

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sim.f --top-module tb_int_div &&
  ./obj_dir/Vtb_int_div | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
